/* logic/echo_config.sv */
`timescale 1ns/1ps

module echo_config
    import udp_echo_pkg::*;
#(
    parameter ip_addr_t  LOCAL_IP    = DEF_LOCAL_IP,
    parameter udp_port_t LISTEN_PORT = DEF_LISTEN_PORT,
    parameter ttl_t      TTL         = DEF_TTL
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        cfg_we_i,
    input  cfg_reg_e    cfg_addr_i,
    input  logic [31:0] cfg_wdata_i,

    output ip_addr_t    local_ip_o,
    output udp_port_t   listen_port_o,
    output ttl_t        reply_ttl_o
);

    ip_addr_t  local_ip_q;
    udp_port_t listen_port_q;
    ttl_t      reply_ttl_q;

    // Narrow registers keep only the low bits of the write data
    always_ff @(posedge clk) begin
        if (rst) begin
            local_ip_q    <= LOCAL_IP;
            listen_port_q <= LISTEN_PORT;
            reply_ttl_q   <= TTL;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                CFG_LOCAL_IP: begin
                    local_ip_q <= cfg_wdata_i[$bits(ip_addr_t)-1:0];
                end
                CFG_LISTEN_PORT: begin
                    listen_port_q <= cfg_wdata_i[$bits(udp_port_t)-1:0];
                end
                CFG_TTL: begin
                    reply_ttl_q <= cfg_wdata_i[$bits(ttl_t)-1:0];
                end
                default: begin
                    // Unmapped address, write ignored
                end
            endcase
        end
    end

    assign local_ip_o    = local_ip_q;
    assign listen_port_o = listen_port_q;
    assign reply_ttl_o   = reply_ttl_q;

endmodule

/* logic/payload_fifo.sv */
`timescale 1ns/1ps

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int FIFO_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst,

    // Write side
    input  byte_t wr_data_i,
    input  logic  wr_last_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,

    // Read side
    output byte_t rd_data_o,
    output logic  rd_last_o,
    output logic  rd_valid_o,
    input  logic  rd_ready_i
);

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t       mem_data [FIFO_DEPTH];
    logic        mem_last [FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;
    logic        full;
    logic        empty;
    logic        do_write;
    logic        do_read;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                   (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign wr_ready_o = !full;
    assign rd_valid_o = !empty;

    assign do_write = wr_valid_i && wr_ready_o;
    assign do_read  = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem_data[wr_ptr_q[AW-1:0]] <= wr_data_i;
            mem_last[wr_ptr_q[AW-1:0]] <= wr_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Head entry, shown as soon as the write pointer moves past it
    assign rd_data_o = mem_data[rd_ptr_q[AW-1:0]];
    assign rd_last_o = mem_last[rd_ptr_q[AW-1:0]];

endmodule

/* logic/port_filter.sv */
`timescale 1ns/1ps

module port_filter
    import udp_echo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  udp_port_t listen_port_i,

    // Receive header
    input  logic      rx_hdr_valid_i,
    input  udp_port_t rx_dst_port_i,
    output logic      rx_hdr_ready_o,

    // Receive payload
    input  byte_t     rx_data_i,
    input  logic      rx_last_i,
    input  logic      rx_valid_i,
    output logic      rx_ready_o,

    // Reply header slot
    input  logic      hdr_free_i,
    output logic      hdr_load_o,

    // FIFO write side
    output byte_t     fifo_data_o,
    output logic      fifo_last_o,
    output logic      fifo_valid_o,
    input  logic      fifo_ready_i
);

    filter_state_e state_q;
    filter_state_e state_d;
    logic          port_match;
    logic          hdr_accept;
    logic          last_accept;

    assign port_match = (rx_dst_port_i == listen_port_i);

    // A matching header waits until the reply slot can take it
    assign rx_hdr_ready_o = (state_q == F_IDLE) && (!port_match || hdr_free_i);
    assign hdr_accept     = rx_hdr_valid_i && rx_hdr_ready_o;
    assign hdr_load_o     = hdr_accept && port_match;

    // Payload steering
    always_comb begin
        case (state_q)
            F_PASS:  rx_ready_o = fifo_ready_i;
            F_DROP:  rx_ready_o = 1'b1;
            default: rx_ready_o = 1'b0;
        endcase
    end

    assign fifo_data_o  = rx_data_i;
    assign fifo_last_o  = rx_last_i;
    assign fifo_valid_o = rx_valid_i && (state_q == F_PASS);

    assign last_accept = rx_valid_i && rx_ready_o && rx_last_i;

    // Fate is decided once per frame, at header acceptance
    always_comb begin
        state_d = state_q;
        case (state_q)
            F_IDLE: begin
                if (hdr_accept) begin
                    state_d = port_match ? F_PASS : F_DROP;
                end
            end
            F_PASS, F_DROP: begin
                if (last_accept) begin
                    state_d = F_IDLE;
                end
            end
            default: begin
                state_d = F_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= F_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* logic/reply_header.sv */
`timescale 1ns/1ps

module reply_header
    import udp_echo_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      hdr_load_i,
    input  ip_addr_t  local_ip_i,
    input  ttl_t      reply_ttl_i,

    // Fields of the received header
    input  ip_addr_t  rx_src_ip_i,
    input  udp_port_t rx_src_port_i,
    input  udp_port_t rx_dst_port_i,
    input  udp_len_t  rx_length_i,

    output logic      hdr_free_o,

    // Reply header
    output logic      tx_hdr_valid_o,
    input  logic      tx_hdr_ready_i,
    output ip_addr_t  tx_src_ip_o,
    output ip_addr_t  tx_dst_ip_o,
    output udp_port_t tx_src_port_o,
    output udp_port_t tx_dst_port_o,
    output udp_len_t  tx_length_o,
    output ttl_t      tx_ttl_o
);

    logic valid_q;

    // Slot can be refilled in the cycle it is being drained
    assign hdr_free_o     = !valid_q || tx_hdr_ready_i;
    assign tx_hdr_valid_o = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (hdr_load_i) begin
            valid_q <= 1'b1;
        end else if (tx_hdr_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // Addresses and ports swapped, config sampled at load time
    always_ff @(posedge clk) begin
        if (hdr_load_i) begin
            tx_src_ip_o   <= local_ip_i;
            tx_dst_ip_o   <= rx_src_ip_i;
            tx_src_port_o <= rx_dst_port_i;
            tx_dst_port_o <= rx_src_port_i;
            tx_length_o   <= rx_length_i;
            tx_ttl_o      <= reply_ttl_i;
        end
    end

endmodule

/* logic/udp_echo_pkg.sv */
package udp_echo_pkg;

    // Header field types
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;
    typedef logic [7:0]  byte_t;

    // Configuration register map, code 3 is unused
    typedef enum logic [1:0] {
        CFG_LOCAL_IP    = 2'd0,
        CFG_LISTEN_PORT = 2'd1,
        CFG_TTL         = 2'd2
    } cfg_reg_e;

    // Fate of the frame currently owning the payload stream
    typedef enum logic [1:0] {
        F_IDLE = 2'd0,
        F_PASS = 2'd1,
        F_DROP = 2'd2
    } filter_state_e;

    // Power-up configuration
    localparam ip_addr_t  DEF_LOCAL_IP    = {8'd192, 8'd168, 8'd2, 8'd128};
    localparam udp_port_t DEF_LISTEN_PORT = 16'd1234;
    localparam ttl_t      DEF_TTL         = 8'd64;

endpackage

/* logic/udp_echo_top.sv */
`timescale 1ns/1ps

module udp_echo_top
    import udp_echo_pkg::*;
#(
    parameter ip_addr_t  LOCAL_IP    = DEF_LOCAL_IP,
    parameter udp_port_t LISTEN_PORT = DEF_LISTEN_PORT,
    parameter ttl_t      TTL         = DEF_TTL,
    parameter int        FIFO_DEPTH  = 64
) (
    input  logic        clk,
    input  logic        rst,

    // Receive header
    input  logic        rx_hdr_valid_i,
    output logic        rx_hdr_ready_o,
    input  ip_addr_t    rx_src_ip_i,
    input  udp_port_t   rx_src_port_i,
    input  udp_port_t   rx_dst_port_i,
    input  udp_len_t    rx_length_i,

    // Receive payload
    input  byte_t       rx_data_i,
    input  logic        rx_last_i,
    input  logic        rx_valid_i,
    output logic        rx_ready_o,

    // Reply header
    output logic        tx_hdr_valid_o,
    input  logic        tx_hdr_ready_i,
    output ip_addr_t    tx_src_ip_o,
    output ip_addr_t    tx_dst_ip_o,
    output udp_port_t   tx_src_port_o,
    output udp_port_t   tx_dst_port_o,
    output udp_len_t    tx_length_o,
    output ttl_t        tx_ttl_o,

    // Reply payload
    output byte_t       tx_data_o,
    output logic        tx_last_o,
    output logic        tx_valid_o,
    input  logic        tx_ready_i,

    // Configuration write
    input  logic        cfg_we_i,
    input  cfg_reg_e    cfg_addr_i,
    input  logic [31:0] cfg_wdata_i
);

    ip_addr_t  local_ip;
    udp_port_t listen_port;
    ttl_t      reply_ttl;
    logic      hdr_load;
    logic      hdr_free;
    byte_t     fifo_data;
    logic      fifo_last;
    logic      fifo_valid;
    logic      fifo_ready;

    echo_config #(
        .LOCAL_IP    (LOCAL_IP),
        .LISTEN_PORT (LISTEN_PORT),
        .TTL         (TTL)
    ) u_config (
        .clk           (clk),
        .rst           (rst),
        .cfg_we_i      (cfg_we_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .local_ip_o    (local_ip),
        .listen_port_o (listen_port),
        .reply_ttl_o   (reply_ttl)
    );

    port_filter u_filter (
        .clk            (clk),
        .rst            (rst),
        .listen_port_i  (listen_port),
        .rx_hdr_valid_i (rx_hdr_valid_i),
        .rx_dst_port_i  (rx_dst_port_i),
        .rx_hdr_ready_o (rx_hdr_ready_o),
        .rx_data_i      (rx_data_i),
        .rx_last_i      (rx_last_i),
        .rx_valid_i     (rx_valid_i),
        .rx_ready_o     (rx_ready_o),
        .hdr_free_i     (hdr_free),
        .hdr_load_o     (hdr_load),
        .fifo_data_o    (fifo_data),
        .fifo_last_o    (fifo_last),
        .fifo_valid_o   (fifo_valid),
        .fifo_ready_i   (fifo_ready)
    );

    reply_header u_header (
        .clk            (clk),
        .rst            (rst),
        .hdr_load_i     (hdr_load),
        .local_ip_i     (local_ip),
        .reply_ttl_i    (reply_ttl),
        .rx_src_ip_i    (rx_src_ip_i),
        .rx_src_port_i  (rx_src_port_i),
        .rx_dst_port_i  (rx_dst_port_i),
        .rx_length_i    (rx_length_i),
        .hdr_free_o     (hdr_free),
        .tx_hdr_valid_o (tx_hdr_valid_o),
        .tx_hdr_ready_i (tx_hdr_ready_i),
        .tx_src_ip_o    (tx_src_ip_o),
        .tx_dst_ip_o    (tx_dst_ip_o),
        .tx_src_port_o  (tx_src_port_o),
        .tx_dst_port_o  (tx_dst_port_o),
        .tx_length_o    (tx_length_o),
        .tx_ttl_o       (tx_ttl_o)
    );

    // Payload of echoed frames only
    payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_data_i  (fifo_data),
        .wr_last_i  (fifo_last),
        .wr_valid_i (fifo_valid),
        .wr_ready_o (fifo_ready),
        .rd_data_o  (tx_data_o),
        .rd_last_o  (tx_last_o),
        .rd_valid_o (tx_valid_o),
        .rd_ready_i (tx_ready_i)
    );

endmodule

/* tb.f */
+incdir+tests
logic/udp_echo_pkg.sv
logic/echo_config.sv
logic/port_filter.sv
logic/reply_header.sv
logic/payload_fifo.sv
logic/udp_echo_top.sv
tests/udp_echo_tb.sv

/* tests/udp_echo_ref.svh */
`ifndef UDP_ECHO_REF_SVH
`define UDP_ECHO_REF_SVH

// Reply header fields, same order as the tx header ports
typedef struct packed {
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;
    ttl_t      ttl;
} reply_hdr_t;

// Returns 1 when the frame is echoed, plus the reply header it should get
function automatic bit echo_expect(
    input  ip_addr_t   local_ip,
    input  udp_port_t  listen_port,
    input  ttl_t       ttl,
    input  ip_addr_t   src_ip,
    input  udp_port_t  src_port,
    input  udp_port_t  dst_port,
    input  udp_len_t   length,
    output reply_hdr_t reply
);
    // Addresses and ports swap, length is copied
    reply.src_ip   = local_ip;
    reply.dst_ip   = src_ip;
    reply.src_port = dst_port;
    reply.dst_port = src_port;
    reply.length   = length;
    reply.ttl      = ttl;
    return dst_port == listen_port;
endfunction

`endif

/* tests/udp_echo_tb.sv */
`timescale 1ns/1ps

module udp_echo_tb
    import udp_echo_pkg::*;
();

    localparam int NUM_RANDOM     = 24;
    localparam int NUM_FRAMES     = 2 * NUM_RANDOM + 3;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (32 + 8) * 4 + 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        rx_hdr_valid_i;
    logic        rx_hdr_ready_o;
    ip_addr_t    rx_src_ip_i;
    udp_port_t   rx_src_port_i;
    udp_port_t   rx_dst_port_i;
    udp_len_t    rx_length_i;
    byte_t       rx_data_i;
    logic        rx_last_i;
    logic        rx_valid_i;
    logic        rx_ready_o;
    logic        tx_hdr_valid_o;
    logic        tx_hdr_ready_i;
    ip_addr_t    tx_src_ip_o;
    ip_addr_t    tx_dst_ip_o;
    udp_port_t   tx_src_port_o;
    udp_port_t   tx_dst_port_o;
    udp_len_t    tx_length_o;
    ttl_t        tx_ttl_o;
    byte_t       tx_data_o;
    logic        tx_last_o;
    logic        tx_valid_o;
    logic        tx_ready_i;
    logic        cfg_we_i;
    cfg_reg_e    cfg_addr_i;
    logic [31:0] cfg_wdata_i;

    `include "udp_echo_ref.svh"

    // Model of the configuration as seen by the next header
    ip_addr_t    cfg_ip   = 32'hc0a8_0280;
    udp_port_t   cfg_port = 16'd1234;
    ttl_t        cfg_ttl  = 8'd64;

    reply_hdr_t  exp_hdr_q [$];
    logic [8:0]  exp_byte_q [$];
    reply_hdr_t  exp_hdr;
    logic [8:0]  exp_byte;
    int          cycles = 0;

    udp_echo_top #(
        .FIFO_DEPTH (16)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid_i (rx_hdr_valid_i),
        .rx_hdr_ready_o (rx_hdr_ready_o),
        .rx_src_ip_i    (rx_src_ip_i),
        .rx_src_port_i  (rx_src_port_i),
        .rx_dst_port_i  (rx_dst_port_i),
        .rx_length_i    (rx_length_i),
        .rx_data_i      (rx_data_i),
        .rx_last_i      (rx_last_i),
        .rx_valid_i     (rx_valid_i),
        .rx_ready_o     (rx_ready_o),
        .tx_hdr_valid_o (tx_hdr_valid_o),
        .tx_hdr_ready_i (tx_hdr_ready_i),
        .tx_src_ip_o    (tx_src_ip_o),
        .tx_dst_ip_o    (tx_dst_ip_o),
        .tx_src_port_o  (tx_src_port_o),
        .tx_dst_port_o  (tx_dst_port_o),
        .tx_length_o    (tx_length_o),
        .tx_ttl_o       (tx_ttl_o),
        .tx_data_o      (tx_data_o),
        .tx_last_o      (tx_last_o),
        .tx_valid_o     (tx_valid_o),
        .tx_ready_i     (tx_ready_i),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_wdata_i    (cfg_wdata_i)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_error($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // Half the frames hit the listen port and the rest miss it
    function automatic udp_port_t random_dst_port();
        udp_port_t port;
        port = $urandom;
        if ($urandom_range(0, 1) == 1) begin
            port = cfg_port;
        end else if (port == cfg_port) begin
            port = ~port;
        end
        return port;
    endfunction

    task automatic write_config(input cfg_reg_e addr, input logic [31:0] data);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk);
        cfg_we_i <= 1'b0;
        case (addr)
            CFG_LOCAL_IP:    cfg_ip   = data;
            CFG_LISTEN_PORT: cfg_port = data[15:0];
            CFG_TTL:         cfg_ttl  = data[7:0];
            default:         cfg_ttl  = cfg_ttl;
        endcase
    endtask

    task automatic send_frame(input udp_port_t dst_port);
        ip_addr_t   src_ip;
        udp_port_t  src_port;
        int         len;
        byte_t      payload [32];
        reply_hdr_t reply;
        src_ip   = $urandom;
        src_port = $urandom;
        len      = $urandom_range(1, 32);
        for (int i = 0; i < len; i++) begin
            payload[i] = $urandom;
        end
        if (echo_expect(cfg_ip, cfg_port, cfg_ttl, src_ip, src_port, dst_port,
                        16'(8 + len), reply)) begin
            exp_hdr_q.push_back(reply);
            for (int i = 0; i < len; i++) begin
                exp_byte_q.push_back({i == len - 1, payload[i]});
            end
        end
        rx_hdr_valid_i <= 1'b1;
        rx_src_ip_i    <= src_ip;
        rx_src_port_i  <= src_port;
        rx_dst_port_i  <= dst_port;
        rx_length_i    <= 16'(8 + len);
        do @(posedge clk); while (!rx_hdr_ready_o);
        rx_hdr_valid_i <= 1'b0;
        for (int i = 0; i < len; i++) begin
            // Occasional gap on the input side
            if ($urandom_range(0, 3) == 0) begin
                rx_valid_i <= 1'b0;
                @(posedge clk);
            end
            rx_valid_i <= 1'b1;
            rx_data_i  <= payload[i];
            rx_last_i  <= (i == len - 1);
            do @(posedge clk); while (!rx_ready_o);
        end
        rx_valid_i <= 1'b0;
    endtask

    // Random stalls on both reply channels
    always @(posedge clk) begin
        tx_hdr_ready_i <= ($urandom_range(0, 3) != 0);
        tx_ready_i     <= ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("Timeout: the run hung before all replies came out");
        end
    end

    // Compare every reply transfer with the oldest expected value
    always @(posedge clk) begin
        if (cycles >= 1 && cycles <= 8) begin
            assert (!tx_hdr_valid_o && !tx_valid_o)
            else stop_on_error("Reply valid was high during or right after reset");
        end
        if (!rst && tx_hdr_valid_o && tx_hdr_ready_i) begin
            assert (exp_hdr_q.size() > 0)
            else stop_on_error("Reply header sent for a frame that should be dropped");
            exp_hdr = exp_hdr_q.pop_front();
            assert (tx_src_ip_o == exp_hdr.src_ip)
            else report_mismatch("tx_src_ip_o", tx_src_ip_o, exp_hdr.src_ip);
            assert (tx_dst_ip_o == exp_hdr.dst_ip)
            else report_mismatch("tx_dst_ip_o", tx_dst_ip_o, exp_hdr.dst_ip);
            assert (tx_src_port_o == exp_hdr.src_port)
            else report_mismatch("tx_src_port_o", tx_src_port_o, exp_hdr.src_port);
            assert (tx_dst_port_o == exp_hdr.dst_port)
            else report_mismatch("tx_dst_port_o", tx_dst_port_o, exp_hdr.dst_port);
            assert (tx_length_o == exp_hdr.length)
            else report_mismatch("tx_length_o", tx_length_o, exp_hdr.length);
            assert (tx_ttl_o == exp_hdr.ttl)
            else report_mismatch("tx_ttl_o", tx_ttl_o, exp_hdr.ttl);
        end
        if (!rst && tx_valid_o && tx_ready_i) begin
            assert (exp_byte_q.size() > 0)
            else stop_on_error("Payload byte sent that no echoed frame carried");
            exp_byte = exp_byte_q.pop_front();
            assert (tx_data_o == exp_byte[7:0])
            else report_mismatch("tx_data_o", tx_data_o, exp_byte[7:0]);
            assert (tx_last_o == exp_byte[8])
            else report_mismatch("tx_last_o", tx_last_o, exp_byte[8]);
        end
    end

    initial begin
        void'($urandom(32'h755d));
        rst            <= 1'b1;
        rx_hdr_valid_i <= 1'b0;
        rx_src_ip_i    <= '0;
        rx_src_port_i  <= '0;
        rx_dst_port_i  <= '0;
        rx_length_i    <= '0;
        rx_data_i      <= '0;
        rx_last_i      <= 1'b0;
        rx_valid_i     <= 1'b0;
        tx_hdr_ready_i <= 1'b0;
        tx_ready_i     <= 1'b0;
        cfg_we_i       <= 1'b0;
        cfg_addr_i     <= CFG_LOCAL_IP;
        cfg_wdata_i    <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Power-up configuration
        send_frame(16'd1234);
        repeat (NUM_RANDOM) send_frame(random_dst_port());

        // New port 8080 with junk in the upper bits that must be ignored
        write_config(CFG_LISTEN_PORT, 32'hdead_1f90);
        write_config(CFG_LOCAL_IP, 32'h0a00_0001);
        write_config(CFG_TTL, 32'h0000_3311);
        write_config(cfg_reg_e'(2'd3), 32'hffff_ffff);
        send_frame(16'd1234);
        send_frame(16'h1f90);
        repeat (NUM_RANDOM) send_frame(random_dst_port());

        while (exp_hdr_q.size() != 0 || exp_byte_q.size() != 0) begin
            @(posedge clk);
        end
        // Idle time to catch any extra output
        repeat (20) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule
